/* fetch_defs.svh */
/*
 * Widths, table size and opcode constants of the instruction-fetch frontend.
 * Included by the type package and by the modules that need a raw constant.
 */

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

// address and instruction word width
`define FETCH_ADDR_W 32

// sequential pc step, one uncompressed instruction
`define INSTR_BYTES 4

// ----------------------------------------------------------------------
// branch history table geometry
// ----------------------------------------------------------------------

// number of 2-bit counters
`define BHT_ENTRIES 16

// index width, taken from pc bits above the word offset
`define BHT_IDX_W 4

// ----------------------------------------------------------------------
// major opcodes of the control-flow instructions
// ----------------------------------------------------------------------

// conditional branches, B-type immediate
`define OPC_BRANCH 7'b1100011

// jump and link, J-type immediate
`define OPC_JAL 7'b1101111

// jump and link register, target unknown at fetch
`define OPC_JALR 7'b1100111

`endif

/* fetch_pkg.sv */
/*
 * Shared types of the instruction-fetch frontend.
 * Imported by every RTL module and by the testbench.
 */

`include "fetch_defs.svh"

package fetch_pkg;

    // ----------------------------------------------------------------------
    // word types
    // ----------------------------------------------------------------------

    // byte address, fetch pc or predicted target
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // raw 32-bit instruction word
    typedef logic [`FETCH_ADDR_W-1:0] instr_t;

    // ----------------------------------------------------------------------
    // branch history table types
    // ----------------------------------------------------------------------

    // table index, pc bits 5 down to 2
    typedef logic [`BHT_IDX_W-1:0] bht_idx_t;

    // saturating counter, upper half means taken
    typedef logic [1:0] bht_cnt_t;

    // ----------------------------------------------------------------------
    // control-flow class of a fetched word
    // ----------------------------------------------------------------------

    // JALR is classified but never predicted taken
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JAL    = 2'd2,
        CF_JALR   = 2'd3
    } cf_kind_e;

endpackage

/* branch_history_table.sv */
/*
 * Branch history table of 2-bit saturating counters with a valid bit each.
 * Read combinationally with the fetch pc; trained by resolved branches
 * from the back end, written at the edge that samples the resolve strobe.
 */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module branch_history_table (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  fetch_pkg::addr_t fetch_pc_i,
    input  logic             upd_valid_i,
    input  logic             upd_is_branch_i,
    input  logic             upd_taken_i,
    input  fetch_pkg::addr_t upd_pc_i,
    output logic             hit_o,
    output logic             taken_o
);
    import fetch_pkg::*;

    // counter value of a freshly validated entry
    localparam bht_cnt_t CNT_WEAK_NT = 2'd1;
    // saturation limits
    localparam bht_cnt_t CNT_MAX = 2'd3;
    localparam bht_cnt_t CNT_MIN = 2'd0;

    // counter storage and per-entry valid bits
    bht_cnt_t                cnt_q [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0] valid_q;

    bht_idx_t rd_idx;
    bht_idx_t wr_idx;
    bht_cnt_t cur_cnt;
    bht_cnt_t new_cnt;
    logic     upd_en;

    // word-aligned pc, skip the two offset bits
    assign rd_idx = fetch_pc_i[`BHT_IDX_W+1:2];
    assign wr_idx = upd_pc_i[`BHT_IDX_W+1:2];

    // ----------------------------------------------------------------------
    // read port
    // ----------------------------------------------------------------------

    assign hit_o   = valid_q[rd_idx];
    // an invalid entry never reports taken
    assign taken_o = valid_q[rd_idx] & cnt_q[rd_idx][1];

    // ----------------------------------------------------------------------
    // update path
    // ----------------------------------------------------------------------

    // only resolved conditional branches train the table
    assign upd_en = upd_valid_i & upd_is_branch_i;

    always_comb begin
        // unseen entry starts from weakly not-taken before the move
        cur_cnt = valid_q[wr_idx] ? cnt_q[wr_idx] : CNT_WEAK_NT;
        new_cnt = cur_cnt;
        if (upd_taken_i) begin
            if (cur_cnt != CNT_MAX) begin
                new_cnt = cur_cnt + 2'd1;
            end
        end else if (cur_cnt != CNT_MIN) begin
            new_cnt = cur_cnt - 2'd1;
        end
    end

    // valid bits, cleared on reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // counter array
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            cnt_q[wr_idx] <= new_cnt;
        end
    end

endmodule

/* instr_scan.sv */
/*
 * Combinational scanner for one uncompressed instruction word.
 * Classifies branch, JAL and JALR by major opcode and extracts the
 * sign-extended offset that the fetch control adds to the pc.
 */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module instr_scan (
    input  fetch_pkg::instr_t   instr_i,
    output fetch_pkg::cf_kind_e kind_o,
    output fetch_pkg::addr_t    imm_o
);
    import fetch_pkg::*;

    logic [6:0] opcode;
    addr_t      imm_b;
    addr_t      imm_j;

    assign opcode = instr_i[6:0];

    // ----------------------------------------------------------------------
    // immediate formats
    // ----------------------------------------------------------------------

    // B-type, imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {
        {(`FETCH_ADDR_W-12){instr_i[31]}},
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // J-type, imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {
        {(`FETCH_ADDR_W-20){instr_i[31]}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    // ----------------------------------------------------------------------
    // classification
    // ----------------------------------------------------------------------

    always_comb begin
        kind_o = CF_NONE;
        imm_o  = '0;
        case (opcode)
            `OPC_BRANCH: begin
                kind_o = CF_BRANCH;
                imm_o  = imm_b;
            end
            `OPC_JAL: begin
                kind_o = CF_JAL;
                imm_o  = imm_j;
            end
            // register target, nothing to extract here
            `OPC_JALR: begin
                kind_o = CF_JALR;
            end
            default: begin
                kind_o = CF_NONE;
            end
        endcase
    end

endmodule

/* fetch_stage_ctrl.sv */
/*
 * Fetch control: taken decision, next-pc priority select, the pc register
 * and the registered fetch entry towards the back end.
 * Redirect strobes clear the entry and load the new pc at the same edge.
 */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_stage_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  fetch_pkg::addr_t    boot_addr_i,
    input  fetch_pkg::cf_kind_e cf_kind_i,
    input  fetch_pkg::addr_t    cf_imm_i,
    input  logic                bht_hit_i,
    input  logic                bht_taken_i,
    input  fetch_pkg::instr_t   fetch_instr_i,
    input  logic                resolve_mispredict_i,
    input  logic                resolve_valid_i,
    input  fetch_pkg::addr_t    resolve_target_i,
    input  logic                ex_valid_i,
    input  logic                eret_i,
    input  logic                set_pc_commit_i,
    input  fetch_pkg::addr_t    trap_base_i,
    input  fetch_pkg::addr_t    epc_i,
    input  fetch_pkg::addr_t    pc_commit_i,
    input  logic                fetch_entry_ready_i,
    output fetch_pkg::addr_t    pc_o,
    output logic                fetch_req_o,
    output logic                fetch_entry_valid_o,
    output logic                fetch_entry_taken_o,
    output fetch_pkg::addr_t    fetch_entry_pc_o,
    output fetch_pkg::addr_t    fetch_entry_target_o,
    output fetch_pkg::instr_t   fetch_entry_instr_o
);
    import fetch_pkg::*;

    // first cycle after reset fetches from the boot address
    logic   boot_load_q;
    addr_t  npc_q;
    addr_t  npc_d;
    addr_t  fetch_addr;
    addr_t  seq_addr;
    addr_t  pred_target;
    logic   pred_taken;
    logic   is_mispredict;
    logic   redirect;
    logic   accept;

    // output entry
    logic   entry_valid_q;
    logic   entry_taken_q;
    addr_t  entry_pc_q;
    addr_t  entry_target_q;
    instr_t entry_instr_q;

    assign fetch_addr = boot_load_q ? boot_addr_i : npc_q;
    assign pc_o       = fetch_addr;

    // slot empty or draining this cycle
    assign fetch_req_o = ~entry_valid_q | fetch_entry_ready_i;
    assign accept      = fetch_req_o;

    // ----------------------------------------------------------------------
    // taken decision
    // ----------------------------------------------------------------------

    always_comb begin
        case (cf_kind_i)
            // dynamic counter if known, else backward taken
            CF_BRANCH: pred_taken = bht_hit_i ? bht_taken_i : cf_imm_i[`FETCH_ADDR_W-1];
            CF_JAL:    pred_taken = 1'b1;
            default:   pred_taken = 1'b0;
        endcase
    end

    assign seq_addr    = fetch_addr + addr_t'(`INSTR_BYTES);
    assign pred_target = fetch_addr + cf_imm_i;

    // ----------------------------------------------------------------------
    // next pc, later assignments win
    // ----------------------------------------------------------------------

    assign is_mispredict = resolve_valid_i & resolve_mispredict_i;
    assign redirect      = is_mispredict | eret_i | ex_valid_i | set_pc_commit_i;

    always_comb begin
        // hold under back-pressure
        npc_d = fetch_addr;
        if (accept) begin
            npc_d = pred_taken ? pred_target : seq_addr;
        end
        if (is_mispredict) begin
            npc_d = resolve_target_i;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_base_i;
        end
        // restart after the committed instruction
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + addr_t'(`INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q   <= 1'b1;
            npc_q         <= '0;
            entry_valid_q <= 1'b0;
        end else begin
            boot_load_q <= 1'b0;
            npc_q       <= npc_d;
            // in-flight fetch is dropped on any redirect
            if (redirect) begin
                entry_valid_q <= 1'b0;
            end else if (accept) begin
                entry_valid_q <= 1'b1;
            end
        end
    end

    // entry payload, loaded with every accepted fetch
    always_ff @(posedge clk_i) begin
        if (accept && !redirect) begin
            entry_pc_q     <= fetch_addr;
            entry_instr_q  <= fetch_instr_i;
            entry_taken_q  <= pred_taken;
            entry_target_q <= pred_target;
        end
    end

    assign fetch_entry_valid_o  = entry_valid_q;
    assign fetch_entry_pc_o     = entry_pc_q;
    assign fetch_entry_instr_o  = entry_instr_q;
    assign fetch_entry_taken_o  = entry_taken_q;
    assign fetch_entry_target_o = entry_target_q;

endmodule

/* fetch_frontend.sv */
/*
 * Top level of the instruction-fetch frontend.
 * Connects the branch history table and the instruction scanner to the
 * fetch control; memory answers fetch_addr_o in the same cycle.
 */

`timescale 1ns/1ps

module fetch_frontend (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  fetch_pkg::addr_t  boot_addr_i,
    // instruction memory
    output logic              fetch_req_o,
    output fetch_pkg::addr_t  fetch_addr_o,
    input  fetch_pkg::instr_t fetch_instr_i,
    // fetch entry towards the back end
    output logic              fetch_entry_valid_o,
    output fetch_pkg::addr_t  fetch_entry_pc_o,
    output fetch_pkg::instr_t fetch_entry_instr_o,
    output logic              fetch_entry_taken_o,
    output fetch_pkg::addr_t  fetch_entry_target_o,
    input  logic              fetch_entry_ready_i,
    // branch resolve from execute
    input  logic              resolve_valid_i,
    input  logic              resolve_is_branch_i,
    input  logic              resolve_taken_i,
    input  logic              resolve_mispredict_i,
    input  fetch_pkg::addr_t  resolve_pc_i,
    input  fetch_pkg::addr_t  resolve_target_i,
    // commit and csr redirects
    input  logic              ex_valid_i,
    input  fetch_pkg::addr_t  trap_base_i,
    input  logic              eret_i,
    input  fetch_pkg::addr_t  epc_i,
    input  logic              set_pc_commit_i,
    input  fetch_pkg::addr_t  pc_commit_i
);
    import fetch_pkg::*;

    addr_t    pc;
    logic     bht_hit;
    logic     bht_taken;
    cf_kind_e cf_kind;
    addr_t    cf_imm;

    assign fetch_addr_o = pc;

    // ----------------------------------------------------------------------
    // prediction sources
    // ----------------------------------------------------------------------

    // trained by resolved branches only
    branch_history_table i_bht (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .fetch_pc_i      (pc),
        .upd_valid_i     (resolve_valid_i),
        .upd_is_branch_i (resolve_is_branch_i),
        .upd_taken_i     (resolve_taken_i),
        .upd_pc_i        (resolve_pc_i),
        .hit_o           (bht_hit),
        .taken_o         (bht_taken)
    );

    // looks at the word straight from memory
    instr_scan i_scan (
        .instr_i (fetch_instr_i),
        .kind_o  (cf_kind),
        .imm_o   (cf_imm)
    );

    // ----------------------------------------------------------------------
    // pc generation and output entry
    // ----------------------------------------------------------------------

    fetch_stage_ctrl i_ctrl (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .boot_addr_i          (boot_addr_i),
        .cf_kind_i            (cf_kind),
        .cf_imm_i             (cf_imm),
        .bht_hit_i            (bht_hit),
        .bht_taken_i          (bht_taken),
        .fetch_instr_i        (fetch_instr_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_target_i     (resolve_target_i),
        .ex_valid_i           (ex_valid_i),
        .eret_i               (eret_i),
        .set_pc_commit_i      (set_pc_commit_i),
        .trap_base_i          (trap_base_i),
        .epc_i                (epc_i),
        .pc_commit_i          (pc_commit_i),
        .fetch_entry_ready_i  (fetch_entry_ready_i),
        .pc_o                 (pc),
        .fetch_req_o          (fetch_req_o),
        .fetch_entry_valid_o  (fetch_entry_valid_o),
        .fetch_entry_taken_o  (fetch_entry_taken_o),
        .fetch_entry_pc_o     (fetch_entry_pc_o),
        .fetch_entry_target_o (fetch_entry_target_o),
        .fetch_entry_instr_o  (fetch_entry_instr_o)
    );

endmodule

/* tb_fetch_frontend.sv */
/*
 * Testbench of the instruction-fetch frontend. A word memory answers the
 * fetches, a cycle model predicts every fetch address and output entry,
 * and a monitor compares the DUT against that model at each rising edge.
 */

`timescale 1ns/1ps

`include "fetch_defs.svh"

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam int         MEM_WORDS  = 256;
    localparam int         WAIT_LIMIT = 300;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic   clk_i = 1'b0;
    logic   rst_ni;
    addr_t  boot_addr_i;
    logic   fetch_req_o;
    addr_t  fetch_addr_o;
    instr_t fetch_instr_i;
    logic   fetch_entry_valid_o;
    addr_t  fetch_entry_pc_o;
    instr_t fetch_entry_instr_o;
    logic   fetch_entry_taken_o;
    addr_t  fetch_entry_target_o;
    logic   fetch_entry_ready_i;
    logic   resolve_valid_i;
    logic   resolve_is_branch_i;
    logic   resolve_taken_i;
    logic   resolve_mispredict_i;
    addr_t  resolve_pc_i;
    addr_t  resolve_target_i;
    logic   ex_valid_i;
    logic   eret_i;
    logic   set_pc_commit_i;
    addr_t  trap_base_i;
    addr_t  epc_i;
    addr_t  pc_commit_i;

    // program words with the class and offset of each word kept aside
    instr_t   mem      [MEM_WORDS];
    cf_kind_e kind_mem [MEM_WORDS];
    addr_t    off_mem  [MEM_WORDS];

    // model state holds the predictor mirror, the next fetch pc and the output slot
    bht_cnt_t                m_cnt [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0] m_valid;
    addr_t                   m_pc;
    logic                    s_valid;
    logic                    s_taken;
    addr_t                   s_pc;
    addr_t                   s_target;
    instr_t                  s_instr;

    int     xfer_cnt;
    int     mismatch_cnt;
    int     timeout_cnt;
    integer seed = 32'hc588;

    always #20 clk_i = ~clk_i;

    // memory answers in the same cycle
    assign fetch_instr_i = mem[fetch_addr_o[9:2]];

    fetch_frontend dut_i (.*);

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    // plain ALU word with every address bit folded into the upper field
    function automatic instr_t fill_word(addr_t a);
        addr_t t;
        t = a ^ {a[22:0], 9'h0} ^ 32'h5a3c_9e10;
        return {t[31:7], OPC_OP_IMM};
    endfunction

    // expected taken flag of the word at pc from the mirrored table
    function automatic logic predict_taken(addr_t pc);
        logic [7:0] w;
        bht_idx_t   i;
        w = pc[9:2];
        i = pc[5:2];
        case (kind_mem[w])
            // counter when known and backward taken otherwise
            CF_BRANCH: return m_valid[i] ? m_cnt[i][1] : off_mem[w][31];
            CF_JAL:    return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    // saturating update where unseen entries start weakly not-taken
    function automatic void train_model(addr_t pc, logic taken);
        bht_idx_t i;
        bht_cnt_t c;
        i = pc[5:2];
        c = m_valid[i] ? m_cnt[i] : 2'd1;
        if (taken && c != 2'd3) begin
            c = c + 2'd1;
        end else if (!taken && c != 2'd0) begin
            c = c - 2'd1;
        end
        m_cnt[i]   = c;
        m_valid[i] = 1'b1;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor comparing pre-edge values against the model
    // ----------------------------------------------------------------------

    always @(posedge clk_i) begin
        logic  accept;
        logic  redirect;
        addr_t redir_pc;
        if (!rst_ni) begin
            m_pc    = boot_addr_i;
            s_valid = 1'b0;
            m_valid = '0;
        end else begin
            expect_bit("fetch_entry_valid_o", fetch_entry_valid_o, s_valid);
            // checked every cycle so a held entry must stay stable
            if (s_valid) begin
                check_addr("fetch_entry_pc_o", fetch_entry_pc_o, s_pc);
                compare_instr("fetch_entry_instr_o", fetch_entry_instr_o, s_instr);
                expect_bit("fetch_entry_taken_o", fetch_entry_taken_o, s_taken);
                check_addr("fetch_entry_target_o", fetch_entry_target_o, s_target);
                if (fetch_entry_ready_i) begin
                    xfer_cnt++;
                end
            end
            accept = !s_valid || fetch_entry_ready_i;
            expect_bit("fetch_req_o", fetch_req_o, accept);
            check_addr("fetch_addr_o", fetch_addr_o, m_pc);
            // highest priority first
            redirect = 1'b1;
            if (set_pc_commit_i) begin
                redir_pc = pc_commit_i + addr_t'(`INSTR_BYTES);
            end else if (ex_valid_i) begin
                redir_pc = trap_base_i;
            end else if (eret_i) begin
                redir_pc = epc_i;
            end else if (resolve_valid_i && resolve_mispredict_i) begin
                redir_pc = resolve_target_i;
            end else begin
                redirect = 1'b0;
                redir_pc = m_pc;
            end
            if (redirect) begin
                s_valid = 1'b0;
                m_pc    = redir_pc;
            end else if (accept) begin
                s_valid  = 1'b1;
                s_pc     = m_pc;
                s_instr  = mem[m_pc[9:2]];
                s_taken  = predict_taken(m_pc);
                s_target = m_pc + off_mem[m_pc[9:2]];
                m_pc     = s_taken ? s_target : m_pc + addr_t'(`INSTR_BYTES);
            end
            // table write lands after this cycle's prediction
            if (resolve_valid_i && resolve_is_branch_i) begin
                train_model(resolve_pc_i, resolve_taken_i);
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------

    task automatic place_cf(input addr_t a, input cf_kind_e k, input addr_t o);
        kind_mem[a[9:2]] = k;
        off_mem[a[9:2]]  = o;
        case (k)
            CF_BRANCH: mem[a[9:2]] = {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11],
                                      `OPC_BRANCH};
            CF_JAL:    mem[a[9:2]] = {o[20], o[10:1], o[11], o[19:12], 5'd1, `OPC_JAL};
            default:   mem[a[9:2]] = {12'h0, 5'd1, 3'b000, 5'd0, `OPC_JALR};
        endcase
    endtask

    task automatic wait_transfers(input int n);
        int target;
        int cycles;
        target = xfer_cnt + n;
        cycles = 0;
        while (xfer_cnt < target && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (xfer_cnt < target) begin
            timeout_cnt++;
            $display("timeout: %0d entries still missing after %0d cycles",
                     target - xfer_cnt, cycles);
        end
    endtask

    // one-cycle branch resolve that trains the table only
    task automatic pulse_resolve(input addr_t pc, input logic taken);
        @(negedge clk_i);
        resolve_valid_i     = 1'b1;
        resolve_is_branch_i = 1'b1;
        resolve_taken_i     = taken;
        resolve_pc_i        = pc;
        @(negedge clk_i);
        resolve_valid_i     = 1'b0;
        resolve_is_branch_i = 1'b0;
    endtask

    // sel bit 0 is mispredict, then eret, exception and commit pc
    task automatic raise_redirect(input logic [3:0] sel, input addr_t base);
        @(negedge clk_i);
        resolve_valid_i      = sel[0];
        resolve_mispredict_i = sel[0];
        resolve_target_i     = base;
        eret_i               = sel[1];
        epc_i                = base + 32'h40;
        ex_valid_i           = sel[2];
        trap_base_i          = base + 32'h80;
        set_pc_commit_i      = sel[3];
        pc_commit_i          = base + 32'hc0;
        @(negedge clk_i);
        resolve_valid_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        eret_i               = 1'b0;
        ex_valid_i           = 1'b0;
        set_pc_commit_i      = 1'b0;
    endtask

    task automatic redirect_run(input logic [3:0] sel);
        addr_t base;
        base = $random(seed) & 32'h3fc;
        raise_redirect(sel, base);
        wait_transfers(5);
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [8:0] k;
        rst_ni               = 1'b0;
        boot_addr_i          = 32'h0000_0100;
        fetch_entry_ready_i  = 1'b1;
        resolve_valid_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_pc_i         = '0;
        resolve_target_i     = '0;
        ex_valid_i           = 1'b0;
        eret_i               = 1'b0;
        set_pc_commit_i      = 1'b0;
        trap_base_i          = '0;
        epc_i                = '0;
        pc_commit_i          = '0;
        xfer_cnt             = 0;
        mismatch_cnt         = 0;
        timeout_cnt          = 0;
        for (k = 9'd0; k < 9'd256; k++) begin
            mem[k[7:0]]      = fill_word({22'b0, k[7:0], 2'b00});
            kind_mem[k[7:0]] = CF_NONE;
            off_mem[k[7:0]]  = '0;
        end
        // straight line from boot into a JAL and a loop closed by a backward branch
        place_cf(32'h120, CF_JAL, 32'h40);
        place_cf(32'h164, CF_JALR, 32'h0);
        place_cf(32'h168, CF_BRANCH, 32'h10);
        place_cf(32'h170, CF_BRANCH, 32'hffff_fff0);
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        wait_transfers(24);
        // forward branch trained to taken
        pulse_resolve(32'h168, 1'b1);
        pulse_resolve(32'h168, 1'b1);
        wait_transfers(12);
        // a third taken update holds the counter at the top
        pulse_resolve(32'h168, 1'b1);
        // trap base 0x160 restarts the loop so the branch is fetched again
        raise_redirect(4'b0100, 32'h0e0);
        wait_transfers(12);
        // not-taken updates reverse it and hold the counter at zero
        repeat (4) begin
            pulse_resolve(32'h168, 1'b0);
        end
        raise_redirect(4'b0100, 32'h0e0);
        wait_transfers(12);
        repeat (8) begin
            pulse_resolve((($random(seed) & 1) != 0) ? 32'h168 : 32'h170,
                          ($random(seed) & 1) != 0);
            wait_transfers(3);
        end
        // single redirects and then combined ones
        redirect_run(4'b0001);
        redirect_run(4'b0010);
        redirect_run(4'b0100);
        redirect_run(4'b1000);
        redirect_run(4'b1111);
        redirect_run(4'b0011);
        redirect_run(4'b0101);
        redirect_run(4'b0110);
        // mispredict flag without resolve_valid_i is ignored
        @(negedge clk_i);
        resolve_mispredict_i = 1'b1;
        resolve_target_i     = 32'h200;
        @(negedge clk_i);
        resolve_mispredict_i = 1'b0;
        wait_transfers(3);
        // random back-pressure over the branch loop
        raise_redirect(4'b0100, 32'h0e0);
        repeat (160) begin
            @(negedge clk_i);
            fetch_entry_ready_i = ($random(seed) & 1) != 0;
        end
        @(negedge clk_i);
        fetch_entry_ready_i = 1'b1;
        wait_transfers(4);
        $display("transfers %0d, mismatches %0d, timeouts %0d",
                 xfer_cnt, mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* fetch_frontend.f */
+incdir+.
fetch_pkg.sv
branch_history_table.sv
instr_scan.sv
fetch_stage_ctrl.sv
fetch_frontend.sv
tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the fetch frontend testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_fetch_frontend -f fetch_frontend.f \
    -o sim_fetch_frontend > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_fetch_frontend > sim.log 2>&1
cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
